/* all.f */
+incdir+hdl
hdl/mem_pkg.sv
hdl/graph_pkg.sv
hdl/chunk_if.sv
hdl/sync_fifo.sv
hdl/edge_fetch_seq.sv
hdl/edge_line_unpack.sv
hdl/edge_job_ctrl.sv
test/tb_clock.sv
test/tb_edge_job_ctrl.sv

/* hdl/chunk_if.sv */
/*
 * Chunk descriptor from sequencer to unpacker, and done back.
 * One chunk is open at a time.
 */
`default_nettype none

`include "edge_cfg.svh"

interface chunk_if;

	// Start pulses for one cycle and the descriptor holds until done
	logic                    start;
	logic [`COUNT_BITS-1:0]  count;
	logic [`LANE_BITS-1:0]   lane;
	logic [`DEGREE_BITS-1:0] first_id;

	// Pulsed with the chunk's last edge
	logic                    done;

	modport seq (output start, count, lane, first_id, input done);
	modport unpack (input start, count, lane, first_id, output done);

endinterface

`default_nettype wire

/* hdl/edge_cfg.svh */
/*
 * Sizes and queue depths shared by the edge fetch stage.
 * Include wherever a width or depth is needed.
 */
`ifndef EDGE_CFG_SVH
`define EDGE_CFG_SVH

// Memory geometry
`define EDGE_BYTES 4
`define LINE_BYTES 16
`define ADDR_BITS 32
`define DEGREE_BITS 16

// Derived widths
`define EDGE_BITS (`EDGE_BYTES * 8)
`define LINE_BITS (`LINE_BYTES * 8)
`define LINE_EDGES (`LINE_BYTES / `EDGE_BYTES)
`define LANE_BITS $clog2(`LINE_EDGES)
`define COUNT_BITS ($clog2(`LINE_EDGES) + 1)

// Queue depths
`define CMD_FIFO_DEPTH 4
`define EDGE_FIFO_DEPTH 16

`endif

/* hdl/edge_fetch_seq.sv */
/*
 * Splits a vertex's edge range into line-sized chunks and issues
 * src, dest and weight reads per chunk, then opens the chunk.
 */
`default_nettype none

`include "edge_cfg.svh"

module edge_fetch_seq (
	input  wire logic                    clock,
	input  wire logic                    rstn,
	input  wire logic                    vertex_valid,
	input  wire logic [`DEGREE_BITS-1:0] vertex_edge_idx,
	input  wire logic [`DEGREE_BITS-1:0] vertex_degree,
	output logic                         vertex_busy,
	input  wire logic [`ADDR_BITS-1:0]   base_src,
	input  wire logic [`ADDR_BITS-1:0]   base_dest,
	input  wire logic [`ADDR_BITS-1:0]   base_weight,
	input  wire logic                    cmd_full,
	output logic                         cmd_push,
	output mem_pkg::read_cmd_t           cmd_data,
	chunk_if.seq                         chunk
);

	import mem_pkg::*;
	import graph_pkg::*;

	localparam int AW         = `ADDR_BITS;
	localparam int DW         = `DEGREE_BITS;
	localparam int CW         = `COUNT_BITS;
	localparam int LINE_SHIFT = $clog2(`LINE_BYTES);
	localparam int EDGE_SHIFT = $clog2(`EDGE_BYTES);

	typedef enum logic [2:0] {
		S_IDLE,
		S_CALC,
		S_ISSUE_SRC,
		S_ISSUE_DEST,
		S_ISSUE_WEIGHT,
		S_START,
		S_WAIT_DONE
	} state_e;

	state_e                state;
	state_e                state_next;
	vertex_job_t           job_in;
	logic [AW-1:0]         next_offset;
	logic [AW-1:0]         aligned;
	logic [AW-1:0]         chunk_aligned;
	logic [DW-1:0]         remaining;
	logic [DW-1:0]         next_id;
	logic [`LANE_BITS-1:0] lane_calc;
	logic [CW-1:0]         lane_room;
	logic [CW-1:0]         count_calc;
	logic                  issuing;

	assign job_in.edge_idx = vertex_edge_idx;
	assign job_in.degree   = vertex_degree;

	//////////////////////////////////////////////////
	// Chunk geometry from the current byte offset
	//////////////////////////////////////////////////

	assign aligned    = next_offset & ~AW'(`LINE_BYTES - 1);
	assign lane_calc  = next_offset[LINE_SHIFT-1:EDGE_SHIFT];
	assign lane_room  = CW'(`LINE_EDGES) - CW'(lane_calc);
	// Never cross into the next line
	assign count_calc = (remaining < DW'(lane_room)) ? CW'(remaining) : lane_room;

	//////////////////////////////////////////////////
	// Chunk FSM
	//////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE: begin
				if (vertex_valid) begin
					state_next = S_CALC;
				end
			end
			S_CALC: begin
				state_next = (remaining == '0) ? S_IDLE : S_ISSUE_SRC;
			end
			S_ISSUE_SRC: begin
				if (!cmd_full) begin
					state_next = S_ISSUE_DEST;
				end
			end
			S_ISSUE_DEST: begin
				if (!cmd_full) begin
					state_next = S_ISSUE_WEIGHT;
				end
			end
			S_ISSUE_WEIGHT: begin
				if (!cmd_full) begin
					state_next = S_START;
				end
			end
			S_START: begin
				state_next = S_WAIT_DONE;
			end
			S_WAIT_DONE: begin
				if (chunk.done) begin
					state_next = S_CALC;
				end
			end
			default: begin
				state_next = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state       <= S_IDLE;
			next_offset <= '0;
			remaining   <= '0;
			next_id     <= '0;
		end else begin
			state <= state_next;
			if (state == S_IDLE && vertex_valid) begin
				next_offset <= AW'(job_in.edge_idx) << EDGE_SHIFT;
				remaining   <= job_in.degree;
				next_id     <= '0;
			end
			if (state == S_CALC && remaining != '0) begin
				next_offset <= aligned + AW'(`LINE_BYTES);
				remaining   <= remaining - DW'(count_calc);
			end
			if (state == S_WAIT_DONE && chunk.done) begin
				next_id <= next_id + DW'(chunk.count);
			end
		end
	end

	// Descriptor stays put until the chunk is done
	always_ff @(posedge clock) begin
		if (state == S_CALC) begin
			chunk_aligned <= aligned;
			chunk.lane    <= lane_calc;
			chunk.count   <= count_calc;
		end
	end

	//////////////////////////////////////////////////
	// Read commands and chunk start
	//////////////////////////////////////////////////

	assign issuing = (state == S_ISSUE_SRC) || (state == S_ISSUE_DEST) ||
		(state == S_ISSUE_WEIGHT);
	assign cmd_push       = issuing && !cmd_full;
	assign vertex_busy    = (state != S_IDLE);
	assign chunk.start    = (state == S_START);
	assign chunk.first_id = next_id;

	always_comb begin
		cmd_data.addr  = base_src + chunk_aligned;
		cmd_data.array = ARRAY_SRC;
		case (state)
			S_ISSUE_DEST: begin
				cmd_data.addr  = base_dest + chunk_aligned;
				cmd_data.array = ARRAY_DEST;
			end
			S_ISSUE_WEIGHT: begin
				cmd_data.addr  = base_weight + chunk_aligned;
				cmd_data.array = ARRAY_WEIGHT;
			end
			default: begin
				cmd_data.array = ARRAY_SRC;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/edge_job_ctrl.sv */
/*
 * Edge fetch stage top level. Takes vertex jobs, issues line reads,
 * and presents unpacked edges through a request-popped queue.
 */
`default_nettype none

`include "edge_cfg.svh"

module edge_job_ctrl (
	input  wire logic                    clock,
	input  wire logic                    rstn,
	// Vertex job
	input  wire logic                    vertex_valid,
	input  wire logic [`DEGREE_BITS-1:0] vertex_edge_idx,
	input  wire logic [`DEGREE_BITS-1:0] vertex_degree,
	output logic                         vertex_busy,
	// Array base addresses
	input  wire logic [`ADDR_BITS-1:0]   base_src,
	input  wire logic [`ADDR_BITS-1:0]   base_dest,
	input  wire logic [`ADDR_BITS-1:0]   base_weight,
	// Read commands
	output logic                         cmd_valid,
	output logic [`ADDR_BITS-1:0]        cmd_addr,
	output mem_pkg::array_sel_e          cmd_array,
	input  wire logic                    cmd_grant,
	// Returned lines
	input  wire logic                    data_valid,
	input  wire mem_pkg::array_sel_e     data_array,
	input  wire logic [`LINE_BITS-1:0]   data_line,
	// Edge queue head
	output logic                         edge_valid,
	output logic [`EDGE_BITS-1:0]        edge_src,
	output logic [`EDGE_BITS-1:0]        edge_dest,
	output logic [`EDGE_BITS-1:0]        edge_weight,
	output logic [`DEGREE_BITS-1:0]      edge_id,
	input  wire logic                    edge_request
);

	import mem_pkg::*;
	import graph_pkg::*;

	chunk_if chunk ();

	read_cmd_t cmd_in;
	read_cmd_t cmd_head;
	logic      cmd_push;
	logic      cmd_full;
	logic      cmd_empty;
	edge_t     edge_in;
	edge_t     edge_head;
	logic      edge_push;
	logic      edge_room;
	logic      edge_empty;

	edge_fetch_seq i_edge_fetch_seq (
		.clock           (clock),
		.rstn            (rstn),
		.vertex_valid    (vertex_valid),
		.vertex_edge_idx (vertex_edge_idx),
		.vertex_degree   (vertex_degree),
		.vertex_busy     (vertex_busy),
		.base_src        (base_src),
		.base_dest       (base_dest),
		.base_weight     (base_weight),
		.cmd_full        (cmd_full),
		.cmd_push        (cmd_push),
		.cmd_data        (cmd_in),
		.chunk           (chunk.seq)
	);

	sync_fifo #(
		.WIDTH ($bits(read_cmd_t)),
		.DEPTH (`CMD_FIFO_DEPTH)
	) cmd_fifo (
		.clock    (clock),
		.rstn     (rstn),
		.push     (cmd_push),
		.data_in  (cmd_in),
		.pop      (cmd_grant),
		.data_out (cmd_head),
		.empty    (cmd_empty),
		.full     (cmd_full),
		.room     ()
	);

	edge_line_unpack i_edge_line_unpack (
		.clock      (clock),
		.rstn       (rstn),
		.data_valid (data_valid),
		.data_array (data_array),
		.data_line  (data_line),
		.edge_space (edge_room),
		.edge_push  (edge_push),
		.edge_data  (edge_in),
		.chunk      (chunk.unpack)
	);

	// Unpacker waits on room, so full is never reached with a push
	sync_fifo #(
		.WIDTH ($bits(edge_t)),
		.DEPTH (`EDGE_FIFO_DEPTH)
	) edge_fifo (
		.clock    (clock),
		.rstn     (rstn),
		.push     (edge_push),
		.data_in  (edge_in),
		.pop      (edge_request),
		.data_out (edge_head),
		.empty    (edge_empty),
		.full     (),
		.room     (edge_room)
	);

	assign cmd_valid   = !cmd_empty;
	assign cmd_addr    = cmd_head.addr;
	assign cmd_array   = cmd_head.array;
	assign edge_valid  = !edge_empty;
	assign edge_src    = edge_head.src;
	assign edge_dest   = edge_head.dest;
	assign edge_weight = edge_head.weight;
	assign edge_id     = edge_head.id;

endmodule

`default_nettype wire

/* hdl/edge_line_unpack.sv */
/*
 * Holds the three tagged lines of a chunk and emits its edges one
 * per cycle from the chunk's first lane, then signals done.
 */
`default_nettype none

`include "edge_cfg.svh"

module edge_line_unpack (
	input  wire logic               clock,
	input  wire logic               rstn,
	input  wire logic               data_valid,
	input  wire mem_pkg::array_sel_e data_array,
	input  wire mem_pkg::cacheline_u data_line,
	input  wire logic               edge_space,
	output logic                    edge_push,
	output graph_pkg::edge_t        edge_data,
	chunk_if.unpack                 chunk
);

	import mem_pkg::*;

	localparam int CW = `COUNT_BITS;
	localparam int DW = `DEGREE_BITS;

	cacheline_u            line_src;
	cacheline_u            line_dest;
	cacheline_u            line_weight;
	logic                  src_ready;
	logic                  dest_ready;
	logic                  weight_ready;
	logic                  lines_ready;
	logic                  chunk_open;
	logic                  shifting;
	logic                  last_edge;
	logic [`LANE_BITS-1:0] lane_ptr;
	logic [CW-1:0]         pos;

	assign lines_ready = src_ready && dest_ready && weight_ready;
	assign last_edge   = shifting && ((pos + CW'(1)) == chunk.count);

	//////////////////////////////////////////////////
	// Tagged line capture
	//////////////////////////////////////////////////

	// Lines may land before the chunk opens
	always_ff @(posedge clock) begin
		if (data_valid) begin
			case (data_array)
				ARRAY_SRC:    line_src.raw    <= data_line.raw;
				ARRAY_DEST:   line_dest.raw   <= data_line.raw;
				ARRAY_WEIGHT: line_weight.raw <= data_line.raw;
				default:      line_src.raw    <= line_src.raw;
			endcase
		end
	end

	// Edge record from the current lane
	always_ff @(posedge clock) begin
		if (shifting) begin
			edge_data.src    <= line_src.lane[lane_ptr];
			edge_data.dest   <= line_dest.lane[lane_ptr];
			edge_data.weight <= line_weight.lane[lane_ptr];
			edge_data.id     <= chunk.first_id + DW'(pos);
		end
	end

	//////////////////////////////////////////////////
	// Chunk control
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			src_ready    <= 1'b0;
			dest_ready   <= 1'b0;
			weight_ready <= 1'b0;
			chunk_open   <= 1'b0;
			shifting     <= 1'b0;
			lane_ptr     <= '0;
			pos          <= '0;
			edge_push    <= 1'b0;
			chunk.done   <= 1'b0;
		end else begin
			edge_push  <= 1'b0;
			chunk.done <= 1'b0;

			if (data_valid) begin
				case (data_array)
					ARRAY_SRC:    src_ready    <= 1'b1;
					ARRAY_DEST:   dest_ready   <= 1'b1;
					ARRAY_WEIGHT: weight_ready <= 1'b1;
					default:      src_ready    <= src_ready;
				endcase
			end

			if (chunk.start) begin
				chunk_open <= 1'b1;
				lane_ptr   <= chunk.lane;
				pos        <= '0;
			end

			// Room for a full line checked once, so no edge is dropped
			if (chunk_open && lines_ready && edge_space && !shifting) begin
				shifting <= 1'b1;
			end

			if (shifting) begin
				edge_push <= 1'b1;
				lane_ptr  <= lane_ptr + 1'b1;
				pos       <= pos + 1'b1;
			end

			// Close the chunk and free the line registers
			if (last_edge) begin
				shifting     <= 1'b0;
				chunk_open   <= 1'b0;
				src_ready    <= 1'b0;
				dest_ready   <= 1'b0;
				weight_ready <= 1'b0;
				chunk.done   <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/graph_pkg.sv */
/*
 * Graph-side types: the vertex job taken in and the edge record
 * handed to the consumer.
 */
`default_nettype none

`include "edge_cfg.svh"

package graph_pkg;

	// Edge range of one vertex
	typedef struct packed {
		logic [`DEGREE_BITS-1:0] edge_idx;
		logic [`DEGREE_BITS-1:0] degree;
	} vertex_job_t;

	// id counts from 0 within each vertex
	typedef struct packed {
		logic [`EDGE_BITS-1:0]   src;
		logic [`EDGE_BITS-1:0]   dest;
		logic [`EDGE_BITS-1:0]   weight;
		logic [`DEGREE_BITS-1:0] id;
	} edge_t;

endpackage

`default_nettype wire

/* hdl/mem_pkg.sv */
/*
 * Memory-side types: which edge array a read targets, the read
 * command word, and the two views of a returned cacheline.
 */
`default_nettype none

`include "edge_cfg.svh"

package mem_pkg;

	// Edge arrays in the order the sequencer reads them
	typedef enum logic [1:0] {
		ARRAY_SRC,
		ARRAY_DEST,
		ARRAY_WEIGHT
	} array_sel_e;

	// Full-line read, tagged so the data can be routed back
	typedef struct packed {
		logic [`ADDR_BITS-1:0] addr;
		array_sel_e            array;
	} read_cmd_t;

	typedef logic [`EDGE_BITS-1:0] edge_word_t;

	// One line as received, or split into edge lanes
	// Lane 0 holds the lowest address
	typedef union packed {
		logic [`LINE_BITS-1:0]         raw;
		edge_word_t [`LINE_EDGES-1:0]  lane;
	} cacheline_u;

endpackage

`default_nettype wire

/* hdl/sync_fifo.sv */
/*
 * First-word-fall-through FIFO for the command and edge queues.
 * The head shows on data_out while empty is low; pop removes it.
 */
`default_nettype none

`include "edge_cfg.svh"

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  wire logic             clock,
	input  wire logic             rstn,
	input  wire logic             push,
	input  wire logic [WIDTH-1:0] data_in,
	input  wire logic             pop,
	output logic      [WIDTH-1:0] data_out,
	output logic                  empty,
	output logic                  full,
	output logic                  room
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_push;
	logic                do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty    = (count == '0);
	assign full     = (count == CNT_BITS'(DEPTH));
	// Space for a whole line of edges
	assign room     = (DEPTH - int'(count)) >= `LINE_EDGES;
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build the edge fetch stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_edge_job_ctrl

output=$(./obj_dir/Vtb_edge_job_ctrl)
echo "$output"

if grep -qxF "PASS: all tests" <<< "$output"; then
	exit 0
fi
exit 1

/* test/tb_clock.sv */
/*
 * Clock and reset for the testbench.
 * Reset is released a little after a rising edge.
 */
`default_nettype none

module tb_clock (
	output logic clock,
	output logic rstn
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF_PERIOD  = 10;
	localparam int RESET_CYCLES = 16;

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD) clock = ~clock;
	end

	initial begin
		rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#2 rstn = 1'b1;
	end

endmodule

`default_nettype wire

/* test/tb_edge_job_ctrl.sv */
/*
 * Testbench for the edge fetch stage. Feeds vertex jobs, models the
 * memory and the edge consumer, and checks the DUT with assertions.
 */
`default_nettype none

`include "edge_cfg.svh"

module tb_edge_job_ctrl;

	timeunit 1ns;
	timeprecision 1ps;

	import mem_pkg::*;
	import graph_pkg::*;

	localparam logic [`ADDR_BITS-1:0] BASE_SRC    = 32'h0010_0000;
	localparam logic [`ADDR_BITS-1:0] BASE_DEST   = 32'h0024_0000;
	localparam logic [`ADDR_BITS-1:0] BASE_WEIGHT = 32'h0038_0000;
	localparam int WAIT_LIMIT = 4000;

	logic                    clock;
	logic                    rstn;
	logic                    vertex_valid;
	logic [`DEGREE_BITS-1:0] vertex_edge_idx;
	logic [`DEGREE_BITS-1:0] vertex_degree;
	logic                    vertex_busy;
	logic [`ADDR_BITS-1:0]   base_src;
	logic [`ADDR_BITS-1:0]   base_dest;
	logic [`ADDR_BITS-1:0]   base_weight;
	logic                    cmd_valid;
	logic [`ADDR_BITS-1:0]   cmd_addr;
	array_sel_e              cmd_array;
	logic                    cmd_grant = 1'b0;
	logic                    data_valid = 1'b0;
	array_sel_e              data_array = ARRAY_SRC;
	logic [`LINE_BITS-1:0]   data_line = '0;
	logic                    edge_valid;
	logic [`EDGE_BITS-1:0]   edge_src;
	logic [`EDGE_BITS-1:0]   edge_dest;
	logic [`EDGE_BITS-1:0]   edge_weight;
	logic [`DEGREE_BITS-1:0] edge_id;
	logic                    edge_request = 1'b0;

	// Reference queues and their heads as seen by the assertions
	read_cmd_t exp_cmds[$];
	edge_t     exp_edges[$];
	read_cmd_t exp_cmd_head;
	edge_t     exp_edge_head;
	int        exp_cmd_count = 0;
	int        exp_edge_count = 0;

	// Memory model state
	read_cmd_t  pend_cmds[$];
	int         pend_due[$];
	read_cmd_t  granted;
	read_cmd_t  line_cmd;
	cacheline_u line_buf;
	logic       pop_cmd;
	logic       pop_edge;
	int         cycle = 0;
	int         last_due = 0;
	int         due;
	int         grant_wait = 0;
	int         grant_max = 4;
	int         request_rate = 12;
	logic [31:0] rng = 32'd50;

	int errors = 0;
	int timeouts = 0;

	tb_clock i_tb_clock (
		.clock (clock),
		.rstn  (rstn)
	);

	edge_job_ctrl i_edge_job_ctrl (
		.clock           (clock),
		.rstn            (rstn),
		.vertex_valid    (vertex_valid),
		.vertex_edge_idx (vertex_edge_idx),
		.vertex_degree   (vertex_degree),
		.vertex_busy     (vertex_busy),
		.base_src        (base_src),
		.base_dest       (base_dest),
		.base_weight     (base_weight),
		.cmd_valid       (cmd_valid),
		.cmd_addr        (cmd_addr),
		.cmd_array       (cmd_array),
		.cmd_grant       (cmd_grant),
		.data_valid      (data_valid),
		.data_array      (data_array),
		.data_line       (data_line),
		.edge_valid      (edge_valid),
		.edge_src        (edge_src),
		.edge_dest       (edge_dest),
		.edge_weight     (edge_weight),
		.edge_id         (edge_id),
		.edge_request    (edge_request)
	);

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [15:0] lcg_next();
		rng = rng * 32'd1103515245 + 32'd12345;
		return rng[31:16];
	endfunction

	// Memory content is the array number in the top nibble plus byte address
	function automatic logic [`EDGE_BITS-1:0] word_at(array_sel_e array,
		logic [`ADDR_BITS-1:0] addr);
		return (32'(array) << 28) + addr;
	endfunction

	function automatic logic [`ADDR_BITS-1:0] base_of(array_sel_e array);
		case (array)
			ARRAY_DEST:   return BASE_DEST;
			ARRAY_WEIGHT: return BASE_WEIGHT;
			default:      return BASE_SRC;
		endcase
	endfunction

	function automatic void refresh_heads();
		exp_cmd_count  = exp_cmds.size();
		exp_edge_count = exp_edges.size();
		if (exp_cmd_count > 0) begin
			exp_cmd_head = exp_cmds[0];
		end
		if (exp_edge_count > 0) begin
			exp_edge_head = exp_edges[0];
		end
	endfunction

	// Expected reads per chunk and expected edges of one vertex
	task automatic expect_job(input int idx, input int deg);
		int        offset;
		int        remaining;
		int        aligned;
		int        lane;
		int        count;
		int        a;
		int        k;
		read_cmd_t cmd;
		edge_t     e;
		offset    = idx * `EDGE_BYTES;
		remaining = deg;
		while (remaining > 0) begin
			aligned = offset & ~(`LINE_BYTES - 1);
			lane    = (offset % `LINE_BYTES) / `EDGE_BYTES;
			count   = (remaining < `LINE_EDGES - lane) ? remaining : `LINE_EDGES - lane;
			for (a = 0; a < 3; a++) begin
				cmd.array = array_sel_e'(a);
				cmd.addr  = base_of(cmd.array) + aligned;
				exp_cmds.push_back(cmd);
			end
			remaining -= count;
			offset = aligned + `LINE_BYTES;
		end
		for (k = 0; k < deg; k++) begin
			e.src    = word_at(ARRAY_SRC, BASE_SRC + (idx + k) * `EDGE_BYTES);
			e.dest   = word_at(ARRAY_DEST, BASE_DEST + (idx + k) * `EDGE_BYTES);
			e.weight = word_at(ARRAY_WEIGHT, BASE_WEIGHT + (idx + k) * `EDGE_BYTES);
			e.id     = 16'(k);
			exp_edges.push_back(e);
		end
		refresh_heads();
	endtask

	task automatic step();
		@(posedge clock);
		#2;
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (!rstn && n < 100) begin
			step();
			n++;
		end
		if (!rstn) begin
			timeouts++;
			$display("Timeout waiting for reset release");
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (vertex_busy && n < WAIT_LIMIT) begin
			step();
			n++;
		end
		if (vertex_busy) begin
			timeouts++;
			$display("Timeout waiting for vertex_busy to fall");
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while ((exp_cmds.size() > 0 || exp_edges.size() > 0 || vertex_busy) &&
			n < WAIT_LIMIT) begin
			step();
			n++;
		end
		if (exp_cmds.size() > 0 || exp_edges.size() > 0 || vertex_busy) begin
			timeouts++;
			$display("Timeout waiting for all commands and edges to drain");
		end
	endtask

	task automatic run_job(input int idx, input int deg);
		wait_idle();
		expect_job(idx, deg);
		vertex_edge_idx = 16'(idx);
		vertex_degree   = 16'(deg);
		vertex_valid    = 1'b1;
		step();
		vertex_valid = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Memory model and edge consumer
	//////////////////////////////////////////////////

	always begin
		// Outputs are settled at the falling edge
		@(negedge clock);
		pop_cmd       = cmd_valid && cmd_grant;
		granted.addr  = cmd_addr;
		granted.array = cmd_array;
		pop_edge      = edge_valid && edge_request;
		@(posedge clock);
		#2;
		cycle++;
		if (pop_cmd) begin
			due = cycle + 1 + int'(lcg_next() % 4);
			if (due <= last_due) begin
				due = last_due + 1;
			end
			last_due = due;
			pend_cmds.push_back(granted);
			pend_due.push_back(due);
			if (exp_cmds.size() > 0) begin
				void'(exp_cmds.pop_front());
			end
		end
		if (pop_edge && exp_edges.size() > 0) begin
			void'(exp_edges.pop_front());
		end
		refresh_heads();

		// One returned line per cycle, in grant order
		data_valid = 1'b0;
		if (pend_cmds.size() > 0 && pend_due[0] <= cycle) begin
			line_cmd = pend_cmds.pop_front();
			void'(pend_due.pop_front());
			for (int i = 0; i < `LINE_EDGES; i++) begin
				line_buf.lane[i] = word_at(line_cmd.array, line_cmd.addr + i * `EDGE_BYTES);
			end
			data_valid = 1'b1;
			data_array = line_cmd.array;
			data_line  = line_buf.raw;
		end

		cmd_grant = 1'b0;
		if (grant_wait > 0) begin
			grant_wait--;
		end else if (cmd_valid) begin
			cmd_grant  = 1'b1;
			grant_wait = int'(lcg_next()) % grant_max;
		end
		edge_request = int'(lcg_next() % 16) < request_rate;
	end

	//////////////////////////////////////////////////
	// Assertions
	//////////////////////////////////////////////////

	a_reset_idle: assert property (@(posedge clock)
		!rstn |-> !cmd_valid && !edge_valid && !vertex_busy) else begin
		errors++;
		$display("Outputs were not idle during reset");
	end

	// Busy follows an accepted job on the next cycle
	a_busy_rise: assert property (@(posedge clock) disable iff (!rstn)
		vertex_valid && !vertex_busy |=> vertex_busy) else begin
		errors++;
		$display("vertex_busy did not rise after a job was accepted");
	end

	a_cmd_expected: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> exp_cmd_count > 0) else begin
		errors++;
		$display("Command appeared with none expected, addr %h", $sampled(cmd_addr));
	end

	a_cmd_addr: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid && cmd_grant |-> cmd_addr == exp_cmd_head.addr) else begin
		errors++;
		$display("FAILED cmd_addr got %h expected %h", $sampled(cmd_addr), exp_cmd_head.addr);
	end

	a_cmd_array: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid && cmd_grant |-> cmd_array == exp_cmd_head.array) else begin
		errors++;
		$display("FAILED cmd_array got %h expected %h", $sampled(cmd_array),
			exp_cmd_head.array);
	end

	// Head must wait for its grant
	a_cmd_hold: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid && !cmd_grant |=> cmd_valid && $stable(cmd_addr) && $stable(cmd_array))
		else begin
		errors++;
		$display("Command head dropped or changed before its grant");
	end

	a_edge_expected: assert property (@(posedge clock) disable iff (!rstn)
		edge_valid |-> exp_edge_count > 0) else begin
		errors++;
		$display("Edge appeared with none expected, id %h", $sampled(edge_id));
	end

	a_edge_src: assert property (@(posedge clock) disable iff (!rstn)
		edge_valid && edge_request |-> edge_src == exp_edge_head.src) else begin
		errors++;
		$display("FAILED edge_src got %h expected %h", $sampled(edge_src), exp_edge_head.src);
	end

	a_edge_dest: assert property (@(posedge clock) disable iff (!rstn)
		edge_valid && edge_request |-> edge_dest == exp_edge_head.dest) else begin
		errors++;
		$display("FAILED edge_dest got %h expected %h", $sampled(edge_dest),
			exp_edge_head.dest);
	end

	a_edge_weight: assert property (@(posedge clock) disable iff (!rstn)
		edge_valid && edge_request |-> edge_weight == exp_edge_head.weight) else begin
		errors++;
		$display("FAILED edge_weight got %h expected %h", $sampled(edge_weight),
			exp_edge_head.weight);
	end

	a_edge_id: assert property (@(posedge clock) disable iff (!rstn)
		edge_valid && edge_request |-> edge_id == exp_edge_head.id) else begin
		errors++;
		$display("FAILED edge_id got %h expected %h", $sampled(edge_id), exp_edge_head.id);
	end

	a_edge_hold: assert property (@(posedge clock) disable iff (!rstn)
		edge_valid && !edge_request |=> edge_valid && $stable(edge_src) &&
		$stable(edge_dest) && $stable(edge_weight) && $stable(edge_id)) else begin
		errors++;
		$display("Edge head dropped or changed while not requested");
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		vertex_valid    = 1'b0;
		vertex_edge_idx = '0;
		vertex_degree   = '0;
		base_src        = BASE_SRC;
		base_dest       = BASE_DEST;
		base_weight     = BASE_WEIGHT;
		wait_reset();

		// Aligned, misaligned, then an empty vertex on its own
		run_job(8, 8);
		run_job(5, 6);
		wait_drained();
		run_job(3, 0);
		wait_drained();

		// Ids restart per vertex
		run_job(2, 3);
		run_job(13, 7);

		// Consumer mostly stalled
		request_rate = 1;
		run_job(1, 10);
		run_job(6, 9);
		wait_drained();
		request_rate = 12;

		// Long grant gaps
		grant_max = 16;
		run_job(4, 5);
		run_job(11, 4);
		wait_drained();

		assert (exp_cmds.size() == 0 && exp_edges.size() == 0 && pend_cmds.size() == 0)
			else begin
			errors++;
			$display("Expected commands or edges never showed up");
		end

		$display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire
